// File: serial_mul_io.f
logic/serial_mul_pkg.sv
logic/operand_loader.sv
logic/bit_counter.sv
logic/mul_sequencer.sv
logic/shift_add_datapath.sv
logic/display_mux.sv
logic/serial_mul_io.sv
test/serial_mul_io_tb.sv

// File: Bender.yml
package:
  name: serial_mul_io

sources:
  - logic/serial_mul_pkg.sv
  - logic/operand_loader.sv
  - logic/bit_counter.sv
  - logic/mul_sequencer.sv
  - logic/shift_add_datapath.sv
  - logic/display_mux.sv
  - logic/serial_mul_io.sv
  - target: test
    files:
      - test/serial_mul_io_tb.sv

// File: test/serial_mul_io_tb.sv
`timescale 1ns/1ps

module serial_mul_io_tb
    import serial_mul_pkg::*;
();

    localparam logic [39:0] LABEL_IN1 = "IN1";
    localparam logic [39:0] LABEL_IN2 = "IN2";
    localparam logic [39:0] LABEL_OUT = "OUT";
    localparam int RUN_TIMEOUT        = 300;
    localparam int WATCHDOG_CYCLES    = 20000;

    logic           clk;
    logic           resetn;
    logic           switch;
    logic           input_which;
    logic           input_valid;
    logic [31:0]    input_value;
    logic [5:0]     display_number;
    display_reply_t display;
    logic           product_ready;
    logic           led_busy;

    // reference state of the operand loader
    logic [31:0]  seed;
    logic [127:0] model_a;
    logic [127:0] model_b;
    logic [1:0]   model_index;
    logic         model_which;
    logic [255:0] expected;
    logic [255:0] old_expected;

    serial_mul_io u_serial_mul_io (
        .clk            (clk),
        .resetn         (resetn),
        .switch         (switch),
        .input_which    (input_which),
        .input_valid    (input_valid),
        .input_value    (input_value),
        .display_number (display_number),
        .display        (display),
        .product_ready  (product_ready),
        .led_busy       (led_busy)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ************************************************************
    // helpers
    // ************************************************************
    task automatic report_error(input string msg);
        $display("[ERROR] %0t: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic abort_on_timeout(input string what);
        $display("timeout: %s", what);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = seed;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        seed = x;
        return x;
    endfunction

    // strobe one word and follow the loader rule in the model
    task automatic write_word(input logic which, input logic [31:0] value);
        @(posedge clk);
        input_which <= which;
        input_valid <= 1'b1;
        input_value <= value;
        if (which != model_which)
            model_index = 2'd0;
        model_which = which;
        if (which)
            model_b[model_index*32 +: 32] = value;
        else
            model_a[model_index*32 +: 32] = value;
        model_index = model_index + 2'd1;
        @(posedge clk);
        input_valid <= 1'b0;
    endtask

    task automatic set_which(input logic which);
        @(posedge clk);
        input_which <= which;
        if (which != model_which)
            model_index = 2'd0;
        model_which = which;
    endtask

    task automatic check_slot(input logic sw, input int n, input logic exp_valid,
                              input logic [39:0] exp_name, input logic [31:0] exp_value);
        @(posedge clk);
        switch         <= sw;
        display_number <= 6'(n);
        @(posedge clk);
        // reply registered at this edge, read it half a cycle later
        @(negedge clk);
        assert (display.valid == exp_valid)
            else report_error($sformatf("slot %0d valid %0b, expected %0b",
                                        n, display.valid, exp_valid));
        assert (display.name == exp_name)
            else report_error($sformatf("slot %0d name %h, expected %h",
                                        n, display.name, exp_name));
        assert (display.value == exp_value)
            else report_error($sformatf("slot %0d value %h, expected %h",
                                        n, display.value, exp_value));
    endtask

    task automatic check_operand(input logic which);
        set_which(which);
        for (int n = 1; n <= 4; n++)
        begin
            check_slot(1'b0, n, 1'b1, which ? LABEL_IN2 : LABEL_IN1,
                       which ? model_b[(n-1)*32 +: 32] : model_a[(n-1)*32 +: 32]);
        end
    endtask

    task automatic check_product();
        expected = {128'd0, model_a} * {128'd0, model_b};
        for (int n = 1; n <= 8; n++)
        begin
            check_slot(1'b1, n, 1'b1, LABEL_OUT, expected[(n-1)*32 +: 32]);
        end
    endtask

    // called right after the strobe edge of the last write
    task automatic wait_for_product();
        int cycles;
        cycles = 0;
        @(posedge clk);
        @(negedge clk);
        while (!product_ready)
        begin
            assert (led_busy) else report_error("led_busy low during a run");
            @(negedge clk);
            cycles++;
            if (cycles > RUN_TIMEOUT)
                abort_on_timeout("product_ready did not rise after the last write");
        end
        assert (cycles == 129)
            else report_error($sformatf("run took %0d cycles, expected 129", cycles));
        assert (!led_busy) else report_error("led_busy still high with product_ready");
    endtask

    // called right after the strobe edge of a write
    task automatic run_partway(input int n);
        @(posedge clk);
        repeat (n)
        begin
            @(negedge clk);
            assert (led_busy && !product_ready)
                else report_error("run ended early or busy dropped");
        end
    endtask

    // ************************************************************
    // checks that hold on every edge
    // ************************************************************
    busy_ready_exclusive: assert property (
        @(posedge clk) disable iff (!resetn) !(led_busy && product_ready))
        else report_error("led_busy and product_ready high together");

    slot_zero_invalid: assert property (
        @(posedge clk) disable iff (!resetn) (display_number == 6'd0) |=> !display.valid)
        else report_error("slot 0 answered with valid set");

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        abort_on_timeout("simulation did not finish in time");
    end

    // ************************************************************
    // main sequence
    // ************************************************************
    initial
    begin
        resetn         = 1'b0;
        switch         = 1'b0;
        input_which    = 1'b0;
        input_valid    = 1'b0;
        input_value    = '0;
        display_number = '0;
        seed           = 32'h3c83;
        model_a        = '0;
        model_b        = '0;
        model_index    = '0;
        model_which    = 1'b0;
        repeat (16) @(posedge clk);
        resetn <= 1'b1;

        // idle after reset
        @(negedge clk);
        assert (!product_ready && !led_busy && !display.valid)
            else report_error("outputs not idle after reset");
        check_slot(1'b0, 1, 1'b1, LABEL_IN1, 32'd0);

        // full load of both operands, then one run
        for (int i = 0; i < 4; i++)
            write_word(1'b0, next_random());
        for (int i = 0; i < 4; i++)
            write_word(1'b1, next_random());
        wait_for_product();
        check_product();

        // readback in input view
        check_operand(1'b0);
        check_operand(1'b1);
        for (int n = 5; n <= 44; n++)
            check_slot(1'b0, n, 1'b1, LABEL_IN2, 32'd0);
        check_slot(1'b0, 0, 1'b0, 40'd0, 32'd0);

        // restart mid-run, old product must hold
        old_expected = expected;
        write_word(1'b1, next_random());
        run_partway(40);
        check_slot(1'b1, 1, 1'b1, LABEL_OUT, old_expected[31:0]);
        write_word(1'b0, next_random());
        wait_for_product();
        check_product();

        // select change partway through loading A
        write_word(1'b0, next_random());
        write_word(1'b0, next_random());
        set_which(1'b1);
        set_which(1'b0);
        write_word(1'b0, next_random());
        write_word(1'b1, next_random());
        wait_for_product();
        check_product();
        check_operand(1'b0);
        check_operand(1'b1);

        $display("TEST OK");
        $finish;
    end

endmodule

// File: logic/serial_mul_io.sv
`timescale 1ns/1ps

module serial_mul_io
    import serial_mul_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 switch,
    input  logic                 input_which,
    input  logic                 input_valid,
    input  logic [WORD_BITS-1:0] input_value,
    input  logic [5:0]           display_number,
    output display_reply_t       display,
    output logic                 product_ready,
    output logic                 led_busy
);

    operand_pair_t           operands;
    logic                    operand_written;
    logic                    count_clear;
    logic                    count_enable;
    logic                    last_bit;
    logic                    load;
    logic                    step;
    logic                    commit;
    logic [PRODUCT_BITS-1:0] product;

    // ************************************************************
    // operand input and multiplier control
    // ************************************************************
    operand_loader u_operand_loader (
        .clk             (clk),
        .resetn          (resetn),
        .input_valid     (input_valid),
        .input_value     (input_value),
        .input_which     (input_which),
        .operands        (operands),
        .operand_written (operand_written)
    );

    bit_counter u_bit_counter (
        .clk          (clk),
        .resetn       (resetn),
        .count_clear  (count_clear),
        .count_enable (count_enable),
        .last_bit     (last_bit)
    );

    mul_sequencer u_mul_sequencer (
        .clk             (clk),
        .resetn          (resetn),
        .operand_written (operand_written),
        .last_bit        (last_bit),
        .count_clear     (count_clear),
        .count_enable    (count_enable),
        .load            (load),
        .step            (step),
        .commit          (commit),
        .product_ready   (product_ready),
        .led_busy        (led_busy)
    );

    // ************************************************************
    // arithmetic and display
    // ************************************************************
    shift_add_datapath u_shift_add_datapath (
        .clk      (clk),
        .resetn   (resetn),
        .operands (operands),
        .load     (load),
        .step     (step),
        .commit   (commit),
        .product  (product)
    );

    display_mux u_display_mux (
        .clk            (clk),
        .resetn         (resetn),
        .switch         (switch),
        .input_which    (input_which),
        .operands       (operands),
        .product        (product),
        .display_number (display_number),
        .display        (display)
    );

endmodule

// File: logic/display_mux.sv
`timescale 1ns/1ps

module display_mux
    import serial_mul_pkg::*;
(
    input  logic                    clk,
    input  logic                    resetn,
    input  logic                    switch,
    input  logic                    input_which,
    input  operand_pair_t           operands,
    input  logic [PRODUCT_BITS-1:0] product,
    input  logic [5:0]              display_number,
    output display_reply_t          display
);

    logic [PRODUCT_BITS-1:0]       shown;
    logic [PRODUCT_INDEX_BITS-1:0] word_index;
    display_reply_t                reply_next;

    // input view shows A or B, output view shows the product
    always_comb
    begin
        if (switch)
            shown = product;
        else if (input_which)
            shown = {{(PRODUCT_BITS - OPERAND_BITS){1'b0}}, operands.b};
        else
            shown = {{(PRODUCT_BITS - OPERAND_BITS){1'b0}}, operands.a};
    end

    // slots count from 1
    assign word_index = PRODUCT_INDEX_BITS'(display_number - 6'd1);

    always_comb
    begin
        reply_next = '0;
        if ((display_number >= 6'd1) && (display_number <= SLOT_COUNT))
        begin
            reply_next.valid = 1'b1;
            reply_next.name  = switch ? NAME_OUT : (input_which ? NAME_IN2 : NAME_IN1);
            // slots past the last product word read as zero
            if (display_number <= PRODUCT_WORDS)
                reply_next.value = shown[word_index*WORD_BITS +: WORD_BITS];
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
            display <= '0;
        else
            display <= reply_next;
    end

endmodule

// File: logic/shift_add_datapath.sv
`timescale 1ns/1ps

module shift_add_datapath
    import serial_mul_pkg::*;
(
    input  logic                    clk,
    input  logic                    resetn,
    input  operand_pair_t           operands,
    input  logic                    load,
    input  logic                    step,
    input  logic                    commit,
    output logic [PRODUCT_BITS-1:0] product
);

    logic [PRODUCT_BITS-1:0] multiplicand;
    logic [PRODUCT_BITS-1:0] accumulator;
    logic [OPERAND_BITS-1:0] multiplier;

    // ************************************************************
    // shift and add, one multiplier bit per step
    // ************************************************************
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            multiplicand <= {{(PRODUCT_BITS - OPERAND_BITS){1'b0}}, operands.a};
            multiplier   <= operands.b;
            accumulator  <= '0;
        end
        else if (step)
        begin
            if (multiplier[0])
            begin
                accumulator <= accumulator + multiplicand;
            end
            // A moves up as B moves down
            multiplicand <= multiplicand << 1;
            multiplier   <= multiplier >> 1;
        end
    end

    // held result, replaced only when a run completes
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            product <= '0;
        end
        else if (commit)
        begin
            product <= accumulator;
        end
    end

endmodule

// File: logic/mul_sequencer.sv
`timescale 1ns/1ps

module mul_sequencer
    import serial_mul_pkg::*;
(
    input  logic clk,
    input  logic resetn,
    input  logic operand_written,
    input  logic last_bit,
    output logic count_clear,
    output logic count_enable,
    output logic load,
    output logic step,
    output logic commit,
    output logic product_ready,
    output logic led_busy
);

    mul_state_t state;
    mul_state_t state_next;

    // ************************************************************
    // next state, any write restarts the run
    // ************************************************************
    always_comb
    begin
        state_next = state;
        if (operand_written)
        begin
            state_next = ST_CLEAR;
        end
        else
        begin
            case (state)
                ST_CLEAR: state_next = ST_RUN;
                ST_RUN:   state_next = last_bit ? ST_DONE : ST_RUN;
                default:  state_next = state;
            endcase
        end
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state  <= ST_IDLE;
            commit <= 1'b0;
        end
        else
        begin
            state  <= state_next;
            // high for the first cycle of ST_DONE, after the final step
            commit <= (state == ST_RUN) && (state_next == ST_DONE);
        end
    end

    assign load          = (state == ST_CLEAR);
    assign count_clear   = (state == ST_CLEAR);
    assign step          = (state == ST_RUN);
    assign count_enable  = (state == ST_RUN);
    assign product_ready = (state == ST_DONE);
    assign led_busy      = (state == ST_CLEAR) || (state == ST_RUN);

endmodule

// File: logic/bit_counter.sv
`timescale 1ns/1ps

module bit_counter
    import serial_mul_pkg::*;
(
    input  logic clk,
    input  logic resetn,
    input  logic count_clear,
    input  logic count_enable,
    output logic last_bit
);

    logic [COUNT_BITS-1:0] count;

    // clear wins over enable
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            count <= '0;
        end
        else if (count_clear)
        begin
            count <= '0;
        end
        else if (count_enable)
        begin
            count <= count + 1'b1;
        end
    end

    // terminal count, one per multiplier bit
    assign last_bit = (count == COUNT_BITS'(OPERAND_BITS - 1));

endmodule

// File: logic/operand_loader.sv
`timescale 1ns/1ps

module operand_loader
    import serial_mul_pkg::*;
(
    input  logic                 clk,
    input  logic                 resetn,
    input  logic                 input_valid,
    input  logic [WORD_BITS-1:0] input_value,
    input  logic                 input_which,
    output operand_pair_t        operands,
    output logic                 operand_written
);

    logic                  which_q;
    logic                  which_changed;
    logic [INDEX_BITS-1:0] word_index;
    logic [INDEX_BITS-1:0] write_index;

    // a new operand selection starts again at word 0
    assign which_changed = (input_which != which_q);
    assign write_index   = which_changed ? '0 : word_index;

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            which_q         <= 1'b0;
            word_index      <= '0;
            operand_written <= 1'b0;
        end
        else
        begin
            which_q         <= input_which;
            operand_written <= input_valid;
            if (input_valid)
            begin
                // wraps after the last word
                word_index <= write_index + 1'b1;
            end
            else if (which_changed)
            begin
                word_index <= '0;
            end
        end
    end

    // word slice write into the selected operand
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            operands <= '0;
        end
        else if (input_valid)
        begin
            if (input_which == 1'b0)
            begin
                operands.a[write_index*WORD_BITS +: WORD_BITS] <= input_value;
            end
            else
            begin
                operands.b[write_index*WORD_BITS +: WORD_BITS] <= input_value;
            end
        end
    end

endmodule

// File: logic/serial_mul_pkg.sv
package serial_mul_pkg;

    // ************************************************************
    // widths and counts
    // ************************************************************
    localparam int WORD_BITS          = 32;
    localparam int OPERAND_BITS       = 128;
    localparam int OPERAND_WORDS      = OPERAND_BITS / WORD_BITS;
    localparam int PRODUCT_BITS       = 2 * OPERAND_BITS;
    localparam int PRODUCT_WORDS      = PRODUCT_BITS / WORD_BITS;
    localparam int SLOT_COUNT         = 44;
    localparam int NAME_BITS          = 40;

    // index and counter widths derived from the above
    localparam int INDEX_BITS         = $clog2(OPERAND_WORDS);
    localparam int COUNT_BITS         = $clog2(OPERAND_BITS);
    localparam int PRODUCT_INDEX_BITS = $clog2(PRODUCT_WORDS);

    // ascii labels, right aligned and zero padded
    localparam logic [NAME_BITS-1:0] NAME_IN1 = "IN1";
    localparam logic [NAME_BITS-1:0] NAME_IN2 = "IN2";
    localparam logic [NAME_BITS-1:0] NAME_OUT = "OUT";

    // ************************************************************
    // shared types
    // ************************************************************
    typedef struct packed {
        logic [OPERAND_BITS-1:0] a;
        logic [OPERAND_BITS-1:0] b;
    } operand_pair_t;

    // one answer to a display slot request
    typedef struct packed {
        logic                 valid;
        logic [NAME_BITS-1:0] name;
        logic [WORD_BITS-1:0] value;
    } display_reply_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_CLEAR,
        ST_RUN,
        ST_DONE
    } mul_state_t;

endpackage
